// File: rtl/mc_cfg_pkg.sv
`default_nettype none

package mc_cfg_pkg;

  //**************************************************************************
  // Controller sizing
  //**************************************************************************
  localparam int NUM_BANKS = 16;   // Banks served by the drain front end
  localparam int RD_DEPTH  = 4;    // Read entries per bank
  localparam int WR_DEPTH  = 6;    // Write entries per bank
  localparam int ADDR_W    = 14;   // Column address width
  localparam int DATA_W    = 32;   // Write data width

  // Queue pointer widths
  localparam int RD_PTR_W = $clog2(RD_DEPTH);
  localparam int WR_PTR_W = $clog2(WR_DEPTH);

  //**************************************************************************
  // Drain thresholds and bus turnaround
  //**************************************************************************
  localparam int LOW_WM      = 32;                        // Leave write mode at or below
  localparam int HIGH_WM     = 64;                        // Force write mode at or above
  localparam int TURN_CYCLES = 2;                         // Idle issue slots per flip
  localparam int TURN_W      = $clog2(TURN_CYCLES + 1);   // Turnaround counter width

endpackage

`default_nettype wire

// File: rtl/mc_types_pkg.sv
`default_nettype none

package mc_types_pkg;

  import mc_cfg_pkg::*;

  //**************************************************************************
  // Request fields
  //**************************************************************************
  typedef logic [3:0]        bank_t;       // Bank index
  typedef logic [ADDR_W-1:0] col_addr_t;   // Column address of a request
  typedef logic [DATA_W-1:0] wdata_t;      // Write payload

  //**************************************************************************
  // Occupancy counts
  //**************************************************************************
  typedef logic [2:0] rd_cnt_t;     // 0 to RD_DEPTH per bank
  typedef logic [2:0] wr_cnt_t;     // 0 to WR_DEPTH per bank
  typedef logic [6:0] wr_total_t;   // Sum over all banks, peaks at 96

  // Drain direction, also the bus direction of issued commands
  typedef enum logic {
    MODE_READ  = 1'b0,
    MODE_WRITE = 1'b1
  } mode_e;

endpackage

`default_nettype wire

// File: rtl/req_intake.sv
`timescale 1ns/1ps
`default_nettype none

module req_intake (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               req_valid,  // Request strobe
  input  logic                                               req_write,
  input  mc_types_pkg::bank_t                                req_bank,
  input  mc_types_pkg::col_addr_t                            req_addr,
  input  mc_types_pkg::wdata_t                               req_data,
  input  logic                                               pop_valid,  // From scheduler
  input  logic                                               pop_write,
  input  mc_types_pkg::bank_t                                pop_bank,
  output logic [mc_cfg_pkg::NUM_BANKS-1:0]                   rd_full,
  output logic [mc_cfg_pkg::NUM_BANKS-1:0]                   wr_full,
  output logic [mc_cfg_pkg::NUM_BANKS-1:0]                   rd_empty,
  output mc_types_pkg::wr_cnt_t [mc_cfg_pkg::NUM_BANKS-1:0]  wr_count,
  output mc_types_pkg::col_addr_t                            head_addr,  // Head of popped queue
  output mc_types_pkg::wdata_t                               head_data
);

  import mc_cfg_pkg::*;
  import mc_types_pkg::*;

  //**************************************************************************
  // Queue storage and bookkeeping
  //**************************************************************************
  col_addr_t rd_mem      [NUM_BANKS][RD_DEPTH];   // Read column addresses
  col_addr_t wr_addr_mem [NUM_BANKS][WR_DEPTH];   // Write column addresses
  wdata_t    wr_data_mem [NUM_BANKS][WR_DEPTH];   // Write payloads

  logic [RD_PTR_W-1:0] rd_wptr [NUM_BANKS];
  logic [RD_PTR_W-1:0] rd_rptr [NUM_BANKS];
  logic [WR_PTR_W-1:0] wr_wptr [NUM_BANKS];
  logic [WR_PTR_W-1:0] wr_rptr [NUM_BANKS];
  rd_cnt_t             rd_cnt  [NUM_BANKS];      // Read occupancy

  logic [NUM_BANKS-1:0] rd_push, rd_pop, wr_push, wr_pop;

  // One-hot push and pop per bank and kind
  always_comb begin
    rd_push = '0;
    wr_push = '0;
    rd_pop  = '0;
    wr_pop  = '0;
    if (req_valid) begin
      if (req_write) wr_push[req_bank] = 1'b1;
      else           rd_push[req_bank] = 1'b1;
    end
    if (pop_valid) begin
      if (pop_write) wr_pop[pop_bank] = 1'b1;
      else           rd_pop[pop_bank] = 1'b1;
    end
  end

  // Entry write at the tail of the addressed bank
  always_ff @(posedge clk) begin
    if (req_valid && !req_write) rd_mem[req_bank][rd_wptr[req_bank]] <= req_addr;
    if (req_valid && req_write) begin
      wr_addr_mem[req_bank][wr_wptr[req_bank]] <= req_addr;
      wr_data_mem[req_bank][wr_wptr[req_bank]] <= req_data;
    end
  end

  //**************************************************************************
  // Pointers and occupancy, push and pop may hit one bank together
  //**************************************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_wptr  <= '{default: '0};
      rd_rptr  <= '{default: '0};
      wr_wptr  <= '{default: '0};
      wr_rptr  <= '{default: '0};
      rd_cnt   <= '{default: '0};
      wr_count <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (rd_push[b])   // Circular wrap at depth
          rd_wptr[b] <= (rd_wptr[b] == RD_PTR_W'(RD_DEPTH - 1)) ? '0 : rd_wptr[b] + 1'b1;
        if (rd_pop[b])
          rd_rptr[b] <= (rd_rptr[b] == RD_PTR_W'(RD_DEPTH - 1)) ? '0 : rd_rptr[b] + 1'b1;
        if (wr_push[b])   // Depth 6 is not a power of two
          wr_wptr[b] <= (wr_wptr[b] == WR_PTR_W'(WR_DEPTH - 1)) ? '0 : wr_wptr[b] + 1'b1;
        if (wr_pop[b])
          wr_rptr[b] <= (wr_rptr[b] == WR_PTR_W'(WR_DEPTH - 1)) ? '0 : wr_rptr[b] + 1'b1;
        if (rd_push[b] && !rd_pop[b]) rd_cnt[b] <= rd_cnt[b] + 1'b1;
        if (!rd_push[b] && rd_pop[b]) rd_cnt[b] <= rd_cnt[b] - 1'b1;
        if (wr_push[b] && !wr_pop[b]) wr_count[b] <= wr_count[b] + 1'b1;
        if (!wr_push[b] && wr_pop[b]) wr_count[b] <= wr_count[b] - 1'b1;
      end
    end
  end

  // Level flags per bank
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      rd_full[b]  = (rd_cnt[b] == rd_cnt_t'(RD_DEPTH));
      rd_empty[b] = (rd_cnt[b] == '0);
      wr_full[b]  = (wr_count[b] == wr_cnt_t'(WR_DEPTH));
    end
  end

  // Head of the queue the scheduler is popping
  assign head_addr = pop_write ? wr_addr_mem[pop_bank][wr_rptr[pop_bank]]
                               : rd_mem[pop_bank][rd_rptr[pop_bank]];
  assign head_data = wr_data_mem[pop_bank][wr_rptr[pop_bank]];   // Only meaningful on writes

  // Client honours the full levels
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> !(req_write ? wr_full[req_bank] : rd_full[req_bank]));

  // Scheduler only picks banks with work of the popped kind
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid |-> !(pop_write ? (wr_count[pop_bank] == '0) : rd_empty[pop_bank]));

endmodule

`default_nettype wire

// File: rtl/cntr_mode.sv
`timescale 1ns/1ps
`default_nettype none

module cntr_mode (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic [mc_cfg_pkg::NUM_BANKS-1:0]                   rd_empty,  // Per-bank read empty
  input  mc_types_pkg::wr_cnt_t [mc_cfg_pkg::NUM_BANKS-1:0]  wr_count,  // Per-bank write count
  output mc_types_pkg::mode_e                                mode       // Registered drain mode
);

  import mc_cfg_pkg::*;
  import mc_types_pkg::*;

  wr_total_t wr_total;    // Writes queued over all banks
  logic      above_high;
  logic      below_low;
  logic      all_rd_empty;
  mode_e     mode_nxt;

  //**************************************************************************
  // Write total and watermark compares
  //**************************************************************************
  always_comb begin
    wr_total = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      wr_total = wr_total + wr_total_t'(wr_count[b]);
    end
  end

  assign above_high   = (wr_total >= wr_total_t'(HIGH_WM));
  assign below_low    = (wr_total <= wr_total_t'(LOW_WM));
  assign all_rd_empty = &rd_empty;   // No read work anywhere

  //**************************************************************************
  // Two-state drain FSM
  //**************************************************************************
  always_comb begin
    mode_nxt = mode;
    case (mode)
      MODE_READ: begin
        // Too many writes, or nothing else to do
        if (above_high || (all_rd_empty && (wr_total != '0)))
          mode_nxt = MODE_WRITE;
      end
      MODE_WRITE: begin
        // Drained out, or low enough and reads are waiting
        if ((wr_total == '0) || (below_low && !all_rd_empty))
          mode_nxt = MODE_READ;
      end
      default: mode_nxt = MODE_READ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) mode <= MODE_READ;
    else        mode <= mode_nxt;   // One cycle behind the counts
  end

  // Intake never holds more writes than the queues can take
  a_total_bound: assert property (@(posedge clk) disable iff (!rst_n)
    wr_total <= wr_total_t'(NUM_BANKS * WR_DEPTH));

endmodule

`default_nettype wire

// File: rtl/drain_sched.sv
`timescale 1ns/1ps
`default_nettype none

module drain_sched (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  mc_types_pkg::mode_e                                mode,
  input  logic [mc_cfg_pkg::NUM_BANKS-1:0]                   rd_empty,
  input  mc_types_pkg::wr_cnt_t [mc_cfg_pkg::NUM_BANKS-1:0]  wr_count,
  input  logic                                               issue_ok,   // Low during turnaround
  output logic                                               pop_valid,
  output logic                                               pop_write,
  output mc_types_pkg::bank_t                                pop_bank
);

  import mc_cfg_pkg::*;
  import mc_types_pkg::*;

  logic [NUM_BANKS-1:0] eligible;   // Banks with work in the current mode
  bank_t                last_bank;  // Round-robin pointer
  bank_t                cand;
  bank_t                pick;
  logic                 found;

  // Eligible mask follows the drain direction
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      eligible[b] = (mode == MODE_WRITE) ? (wr_count[b] != '0) : !rd_empty[b];
    end
  end

  //**************************************************************************
  // First eligible bank after the last one served
  //**************************************************************************
  always_comb begin
    found = 1'b0;
    pick  = last_bank;
    cand  = last_bank;
    for (int off = 1; off <= NUM_BANKS; off++) begin
      cand = last_bank + bank_t'(off);   // Wraps through all banks, last one is itself
      if (!found && eligible[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  assign pop_valid = issue_ok && found;
  assign pop_write = (mode == MODE_WRITE);   // Direction tracks mode
  assign pop_bank  = pick;

  // Pointer moves only when a request leaves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_bank <= bank_t'(NUM_BANKS - 1);   // Bank 0 goes first
    end else if (pop_valid) begin
      last_bank <= pick;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cmd_out.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_out (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mc_types_pkg::mode_e     mode,
  input  logic                    pop_valid,
  input  logic                    pop_write,
  input  mc_types_pkg::bank_t     pop_bank,
  input  mc_types_pkg::col_addr_t head_addr,   // Combinational head from intake
  input  mc_types_pkg::wdata_t    head_data,
  output logic                    issue_ok,
  output logic                    cmd_valid,
  output logic                    cmd_write,
  output mc_types_pkg::bank_t     cmd_bank,
  output mc_types_pkg::col_addr_t cmd_addr,
  output mc_types_pkg::wdata_t    cmd_data
);

  import mc_cfg_pkg::*;
  import mc_types_pkg::*;

  mode_e             mode_q;     // Mode seen last cycle
  logic [TURN_W-1:0] turn_cnt;   // Remaining turnaround slots

  //**************************************************************************
  // Bus turnaround after a mode flip
  //**************************************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode_q   <= MODE_READ;
      turn_cnt <= '0;
    end else begin
      mode_q <= mode;
      if (mode != mode_q)      turn_cnt <= TURN_W'(TURN_CYCLES);   // Flip just seen
      else if (turn_cnt != '0) turn_cnt <= turn_cnt - 1'b1;
    end
  end

  // Holds off the flip cycle as well
  assign issue_ok = (turn_cnt == '0) && (mode == mode_q);

  // Command register
  always_ff @(posedge clk) begin
    if (!rst_n) cmd_valid <= 1'b0;
    else        cmd_valid <= pop_valid;
  end

  always_ff @(posedge clk) begin
    if (pop_valid) begin
      cmd_write <= pop_write;
      cmd_bank  <= pop_bank;
      cmd_addr  <= head_addr;
      cmd_data  <= pop_write ? head_data : '0;   // Reads carry no data
    end
  end

  // Direction matches the mode of the pop cycle
  a_cmd_dir: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid |-> (cmd_write == ($past(mode) == MODE_WRITE)));

endmodule

`default_nettype wire

// File: rtl/mc_drain_top.sv
`timescale 1ns/1ps
`default_nettype none

module mc_drain_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               req_valid,
  input  logic                               req_write,
  input  mc_types_pkg::bank_t                req_bank,
  input  mc_types_pkg::col_addr_t            req_addr,
  input  mc_types_pkg::wdata_t               req_data,
  output logic [mc_cfg_pkg::NUM_BANKS-1:0]   rd_full,    // Client back-pressure
  output logic [mc_cfg_pkg::NUM_BANKS-1:0]   wr_full,
  output mc_types_pkg::mode_e                mode,
  output logic                               cmd_valid,
  output logic                               cmd_write,
  output mc_types_pkg::bank_t                cmd_bank,
  output mc_types_pkg::col_addr_t            cmd_addr,
  output mc_types_pkg::wdata_t               cmd_data
);

  import mc_cfg_pkg::*;
  import mc_types_pkg::*;

  //**************************************************************************
  // Internal nets
  //**************************************************************************
  logic [NUM_BANKS-1:0]           rd_empty;
  wr_cnt_t [NUM_BANKS-1:0]        wr_count;
  logic                           issue_ok;
  logic                           pop_valid;
  logic                           pop_write;
  bank_t                          pop_bank;
  col_addr_t                      head_addr;
  wdata_t                         head_data;

  req_intake u_intake (         // Per-bank queues
    .clk, .rst_n,
    .req_valid, .req_write, .req_bank, .req_addr, .req_data,
    .pop_valid, .pop_write, .pop_bank,
    .rd_full, .wr_full, .rd_empty, .wr_count,
    .head_addr, .head_data
  );

  cntr_mode u_mode (            // Watermark drain FSM
    .clk, .rst_n,
    .rd_empty, .wr_count,
    .mode
  );

  drain_sched u_sched (         // Round-robin pick
    .clk, .rst_n,
    .mode, .rd_empty, .wr_count, .issue_ok,
    .pop_valid, .pop_write, .pop_bank
  );

  cmd_out u_out (               // Command register and turnaround
    .clk, .rst_n,
    .mode, .pop_valid, .pop_write, .pop_bank, .head_addr, .head_data,
    .issue_ok,
    .cmd_valid, .cmd_write, .cmd_bank, .cmd_addr, .cmd_data
  );

endmodule

`default_nettype wire

// File: sim/tb_mc_drain.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mc_drain;

  import mc_cfg_pkg::*;
  import mc_types_pkg::*;

  localparam int CLK_HALF     = 4;      // 8 ns period
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY  = 1;      // Input skew after the rising edge
  localparam int DRAIN_LIMIT  = 2000;   // Cycles allowed for one drain
  localparam int HIGH_LIMIT   = 6000;   // Cycles allowed to reach HIGH_WM

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_write;
  bank_t                req_bank;
  col_addr_t            req_addr;
  wdata_t               req_data;
  logic [NUM_BANKS-1:0] rd_full;
  logic [NUM_BANKS-1:0] wr_full;
  mode_e                mode;
  logic                 cmd_valid;
  logic                 cmd_write;
  bank_t                cmd_bank;
  col_addr_t            cmd_addr;
  wdata_t               cmd_data;

  mc_drain_top u_dut (.*);

  //**************************************************************************
  // Reference model state
  //**************************************************************************
  col_addr_t   rd_q    [NUM_BANKS][$];   // Expected read addresses per bank
  col_addr_t   wr_aq   [NUM_BANKS][$];   // Expected write addresses
  wdata_t      wr_dq   [NUM_BANKS][$];   // Expected write data
  int          rd_wait [NUM_BANKS];      // Reads issued while bank waited
  int          wr_wait [NUM_BANKS];
  mode_e       ref_mode;
  mode_e       prev_mode;                // DUT mode in the pop cycle
  int          since_flip = 1000;
  int          flips = 0;
  logic        hit_high = 1'b0;
  logic        pend_valid = 1'b0;        // Strobe waiting for its clock edge
  logic        pend_write;
  bank_t       pend_bank;
  col_addr_t   pend_addr;
  wdata_t      pend_data;
  int          wr_tot;
  int          rd_tot;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] rng = 32'hea23b3a7;

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int queued_writes();
    int n;
    n = 0;
    for (int b = 0; b < NUM_BANKS; b++) n += wr_aq[b].size();
    return n;
  endfunction

  function automatic int queued_reads();
    int n;
    n = 0;
    for (int b = 0; b < NUM_BANKS; b++) n += rd_q[b].size();
    return n;
  endfunction

  // Watermark rules on the queued totals
  function automatic mode_e next_mode(input mode_e cur, input int wr_n, input int rd_n);
    if (cur == MODE_READ) begin
      if (wr_n >= HIGH_WM || (rd_n == 0 && wr_n != 0)) return MODE_WRITE;
      return MODE_READ;
    end
    if (wr_n == 0 || (wr_n <= LOW_WM && rd_n != 0)) return MODE_READ;
    return MODE_WRITE;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch %s: got %0h expected %0h", sig, got, exp);
    errors++;
  endtask

  task automatic fail_check(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  //**************************************************************************
  // Command checks, popped entries leave the model
  //**************************************************************************
  task automatic check_cmd();
    col_addr_t drop_a;
    wdata_t    drop_d;
    assert (cmd_write == (prev_mode == MODE_WRITE))
      else report_mismatch("cmd_write", cmd_write, prev_mode);
    assert (since_flip == 0 || since_flip > TURN_CYCLES)
      else fail_check($sformatf("command on bank %0d only %0d cycles after a mode change",
                                cmd_bank, since_flip));
    if (cmd_write) begin
      if (wr_aq[cmd_bank].size() == 0) begin
        fail_check($sformatf("write command on bank %0d with no write queued", cmd_bank));
      end else begin
        assert (cmd_addr == wr_aq[cmd_bank][0])
          else report_mismatch("cmd_addr", cmd_addr, wr_aq[cmd_bank][0]);
        assert (cmd_data == wr_dq[cmd_bank][0])
          else report_mismatch("cmd_data", cmd_data, wr_dq[cmd_bank][0]);
        drop_a = wr_aq[cmd_bank].pop_front();
        drop_d = wr_dq[cmd_bank].pop_front();
      end
    end else begin
      if (rd_q[cmd_bank].size() == 0) begin
        fail_check($sformatf("read command on bank %0d with no read queued", cmd_bank));
      end else begin
        assert (cmd_addr == rd_q[cmd_bank][0])
          else report_mismatch("cmd_addr", cmd_addr, rd_q[cmd_bank][0]);
        drop_a = rd_q[cmd_bank].pop_front();
      end
      assert (cmd_data == '0) else report_mismatch("cmd_data", cmd_data, 0);
    end
    // Round robin bound, one full lap of the banks
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (cmd_write) begin
        if (b == int'(cmd_bank) || wr_aq[b].size() == 0) wr_wait[b] = 0;
        else wr_wait[b]++;
        assert (wr_wait[b] <= NUM_BANKS)
          else fail_check($sformatf("bank %0d write starved for %0d commands", b, wr_wait[b]));
      end else begin
        if (b == int'(cmd_bank) || rd_q[b].size() == 0) rd_wait[b] = 0;
        else rd_wait[b]++;
        assert (rd_wait[b] <= NUM_BANKS)
          else fail_check($sformatf("bank %0d read starved for %0d commands", b, rd_wait[b]));
      end
    end
  endtask

  //**************************************************************************
  // Monitor at the falling edge, outputs are stable here
  //**************************************************************************
  always @(negedge clk) begin
    cycles++;
    if (!rst_n) begin
      if (cycles > 1) begin
        assert (mode == MODE_READ) else report_mismatch("mode", mode, MODE_READ);
        assert (!cmd_valid) else report_mismatch("cmd_valid", cmd_valid, 0);
        assert (rd_full == '0) else report_mismatch("rd_full", rd_full, 0);
        assert (wr_full == '0) else report_mismatch("wr_full", wr_full, 0);
      end
      ref_mode   = MODE_READ;
      prev_mode  = MODE_READ;
      since_flip = 1000;
      pend_valid = 1'b0;
    end else begin
      if (pend_valid) begin   // Stored by the DUT at the last edge
        if (pend_write) begin
          wr_aq[pend_bank].push_back(pend_addr);
          wr_dq[pend_bank].push_back(pend_data);
        end else begin
          rd_q[pend_bank].push_back(pend_addr);
        end
      end
      if (mode != prev_mode) begin   // Turnaround window starts here
        since_flip = 0;
        flips++;
        rd_wait = '{default: 0};
        wr_wait = '{default: 0};
      end else if (since_flip < 1000) begin
        since_flip++;
      end
      if (cmd_valid) check_cmd();
      for (int b = 0; b < NUM_BANKS; b++) begin   // Full levels follow the model depth
        assert (rd_full[b] == (rd_q[b].size() == RD_DEPTH))
          else report_mismatch($sformatf("rd_full[%0d]", b), rd_full[b],
                               rd_q[b].size() == RD_DEPTH);
        assert (wr_full[b] == (wr_aq[b].size() == WR_DEPTH))
          else report_mismatch($sformatf("wr_full[%0d]", b), wr_full[b],
                               wr_aq[b].size() == WR_DEPTH);
      end
      wr_tot = queued_writes();
      rd_tot = queued_reads();
      assert (mode == ref_mode) else report_mismatch("mode", mode, ref_mode);
      ref_mode = next_mode(ref_mode, wr_tot, rd_tot);   // Registered, one cycle late
      if (wr_tot >= HIGH_WM) hit_high = 1'b1;
      pend_valid = req_valid;
      pend_write = req_write;
      pend_bank  = req_bank;
      pend_addr  = req_addr;
      pend_data  = req_data;
      prev_mode  = mode;
    end
  end

  //**************************************************************************
  // Stimulus
  //**************************************************************************
  task automatic drive_idle();
    @(posedge clk);
    #DRIVE_DELAY;
    req_valid = 1'b0;
  endtask

  // Writes while reading and reads while writing when follow_mode is set
  task automatic drive_random(input int wr_pct, input logic follow_mode, input bank_t mask);
    logic  wr;
    bank_t bank;
    @(posedge clk);
    #DRIVE_DELAY;
    rng  = next_rand(rng);
    wr   = follow_mode ? (mode == MODE_READ) : ((int'(rng[7:0]) % 100) < wr_pct);
    bank = rng[11:8] & mask;
    req_valid = !(wr ? wr_full[bank] : rd_full[bank]);   // Skip a full queue
    req_write = wr;
    req_bank  = bank;
    req_addr  = rng[25:12];
    rng       = next_rand(rng);
    req_data  = rng;
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    drive_idle();
    while ((queued_reads() != 0 || queued_writes() != 0 || pend_valid ||
            mode != MODE_READ) && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (n >= DRAIN_LIMIT) fail_check($sformatf("timeout, %s traffic never drained", what));
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", num, name, errors - err_before);
    end
  endtask

  initial begin
    int e0;
    int f0;
    int n;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_bank  = '0;
    req_addr  = '0;
    req_data  = '0;

    e0 = errors;   // Reset state
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    repeat (4) drive_idle();
    assert (!cmd_valid && mode == MODE_READ && rd_full == '0 && wr_full == '0)
      else fail_check("DUT not idle after reset");
    finish_test(1, "reset state", e0);

    e0 = errors;   // Few banks so that per-bank order matters
    repeat (48) drive_random(0, 1'b0, 4'h3);
    wait_drain("read");
    finish_test(2, "read ordering", e0);

    e0 = errors;
    hit_high = 1'b0;
    n = 0;
    while (!hit_high && n < HIGH_LIMIT) begin
      drive_random(0, 1'b1, 4'hf);
      n++;
    end
    if (!hit_high) fail_check("timeout, write total never reached the high watermark");
    wait_drain("accumulated");
    finish_test(3, "write accumulation", e0);

    e0 = errors;
    f0 = flips;
    repeat (60) drive_random(100, 1'b0, 4'hf);
    wait_drain("write");
    if (flips - f0 < 2) fail_check("writes alone never switched the mode to write");
    finish_test(4, "writes only", e0);

    e0 = errors;
    f0 = flips;
    repeat (300) drive_random(50, 1'b0, 4'hf);
    wait_drain("mixed");
    if (flips - f0 < 4) fail_check($sformatf("only %0d mode changes seen", flips - f0));
    finish_test(5, "turnaround", e0);

    e0 = errors;   // Loaded queues on all banks
    repeat (600) drive_random(0, 1'b1, 4'hf);
    wait_drain("loaded");
    finish_test(6, "fairness", e0);

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Hang guard for the whole run
  initial begin
    #(2 * CLK_HALF * 100000);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/mc_cfg_pkg.sv
rtl/mc_types_pkg.sv
rtl/req_intake.sv
rtl/cntr_mode.sv
rtl/drain_sched.sv
rtl/cmd_out.sv
rtl/mc_drain_top.sv
sim/tb_mc_drain.sv

// File: Makefile
# Verilator build and run for the memory controller drain front end

VERILATOR ?= verilator
TOP       ?= tb_mc_drain
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
